// File: files.f
+incdir+source
source/vsaPkg.sv
source/vsaAlu.sv
source/vsaRegFile.sv
source/vsaCore.sv
source/vsaMemory.sv
source/vsaSystem.sv
verification/vsaClockGen.sv
verification/vsaSystem_sva.sv
verification/vsaTb.sv

// File: run.sh
#!/bin/sh
# build and run the vsa testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module vsaTb -o vsaSim

# the simulator exits nonzero on failure; the log decides the result
./obj_dir/vsaSim > sim.log 2>&1 || true
cat sim.log

if grep -q "^Finished with no errors$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// File: source/vsaAlu.sv
// vsa ALU
// combinational result and branch condition for the EX stage

`timescale 1ns/1ps

module vsaAlu import vsaPkg::*; (
    input  decodedT dec,    // decoded IR
    input  wordT    opA,    // A register
    input  wordT    opB,    // B register
    input  wordT    npc,    // NPC, base of branch target
    output wordT    result, // into ALUOutput
    output logic    cond    // into Cond
);

    wordT branchOff; // imm[3:0] in half-instruction units

    assign branchOff = {dec.imm[3:0], 1'b0};

    always_comb begin
        result = '0;
        cond   = 1'b0; // only BEQZ sets it
        case (dec.opcode)
            LW, SW: begin
                result = opA + dec.imm; // effective address
            end
            ALUOP: begin
                case (dec.func)
                    ADD:     result = opA + opB;
                    SUB:     result = opA - opB;
                    AND:     result = opA & opB;
                    OR:      result = opA | opB;
                    XOR:     result = opA ^ opB;
                    NOT:     result = ~opA;
                    SRL:     result = opA >> 1;
                    SRA:     result = wordT'($signed(opA) >>> 1); // msb replicated
                    default: result = '0;
                endcase
            end
            ADDI:    result = opA + dec.imm; // wraps at 5 bits
            SUBI:    result = opA - dec.imm;
            BEQZ: begin
                result = npc + branchOff; // taken target
                cond   = (opA == '0);
            end
            default: result = '0; // opcodes 6 and 7 unused
        endcase
    end

endmodule

// File: source/vsaCore.sv
// vsa core
// five-stage multicycle processor: IF, ID, EX, MEM, WB, no overlap
// holds IR, NPC, A, B, ALUOutput, Cond and LMD plus the PC

`timescale 1ns/1ps
`include "vsa_config.svh"

module vsaCore import vsaPkg::*; (
    input  logic    clock,
    input  logic    rstN,
    input  instrT   instruction, // from instruction memory at pc
    input  wordT    readData,    // data memory at dataBus.addr
    output addrT    pc,
    output dataBusT dataBus
);

    stageE   stage;      // current stage
    instrT   ir;         // instruction register
    addrT    npc;        // pc + step
    wordT    a;          // first operand
    wordT    b;          // second operand, also store data
    wordT    aluOutput;  // result or effective address
    logic    cond;       // branch condition
    wordT    lmd;        // load data

    decodedT dec;
    wordT    rdDataA;
    wordT    rdDataB;
    wordT    aluResult;
    logic    aluCond;
    logic    wbEn;
    regIdxT  wbIdx;
    wordT    wbData;
    logic    isRegWrite; // opcode writes a register at all

    // decode straight from IR, fields overlap as in the ISA
    always_comb begin
        dec.opcode = ir[11:9];
        dec.src1   = ir[8:7];
        dec.src2   = ir[6:5];
        dec.dst    = ir[4:3];
        dec.func   = ir[2:0];
        dec.imm    = ir[4:0];
    end

    // register file, read in ID and written in WB
    vsaRegFile regFile_i (
        .clock   (clock),
        .rstN    (rstN),
        .rdIdxA  (dec.src1),
        .rdIdxB  (dec.src2),
        .rdDataA (rdDataA),
        .rdDataB (rdDataB),
        .wrEn    (wbEn),
        .wrIdx   (wbIdx),
        .wrData  (wbData)
    );

    vsaAlu alu_i (
        .dec    (dec),
        .opA    (a),
        .opB    (b),
        .npc    (npc),
        .result (aluResult),
        .cond   (aluCond)
    );

    // write-back selection
    assign isRegWrite = (dec.opcode == ALUOP) || (dec.opcode == ADDI) ||
                        (dec.opcode == SUBI) || (dec.opcode == LW);
    assign wbEn   = (stage == WB) && isRegWrite;
    assign wbIdx  = (dec.opcode == ALUOP) ? dec.dst : dec.src2; // R vs I format
    assign wbData = (dec.opcode == LW) ? lmd : aluOutput;

    // data bus, store strobe only in MEM of SW
    assign dataBus.addr  = aluOutput;
    assign dataBus.wdata = b;
    assign dataBus.wr    = (stage == MEM) && (dec.opcode == SW);

    always_ff @(posedge clock) begin
        if (!rstN) begin
            stage     <= IF;
            pc        <= '0;
            ir        <= '0;
            npc       <= '0;
            a         <= '0;
            b         <= '0;
            aluOutput <= '0;
            cond      <= 1'b0;
            lmd       <= '0;
        end else begin
            case (stage)
                IF: begin
                    ir    <= instruction;
                    npc   <= pc + addrT'(`VSA_PC_STEP);
                    stage <= ID;
                end
                ID: begin
                    a     <= rdDataA; // R0 already zero from regfile
                    b     <= rdDataB;
                    stage <= EX;
                end
                EX: begin
                    aluOutput <= aluResult;
                    cond      <= aluCond; // low unless BEQZ
                    stage     <= MEM;
                end
                MEM: begin
                    if (dec.opcode == LW) begin
                        lmd <= readData;
                    end
                    // only place the pc moves
                    if (dec.opcode == BEQZ && cond) begin
                        pc <= aluOutput; // taken
                    end else begin
                        pc <= npc;
                    end
                    stage <= WB;
                end
                WB: begin
                    stage <= IF; // regfile write happens via wbEn
                end
                default: begin
                    stage <= IF; // unused encodings recover
                end
            endcase
        end
    end

endmodule

// File: source/vsaMemory.sv
// vsa memories
// instruction array filled through the load port, data array on the bus
// both read combinationally, written on the clock edge

`timescale 1ns/1ps
`include "vsa_config.svh"

module vsaMemory import vsaPkg::*; (
    input  logic     clock,
    input  loadPortT load,        // testbench program load
    input  addrT     fetchAddr,   // core pc
    output instrT    instruction,
    input  dataBusT  dataBus,     // core data bus
    output wordT     readData
);

    localparam int ImemAw = $clog2(`VSA_IMEM_WORDS);

    instrT             imem [`VSA_IMEM_WORDS]; // program store
    wordT              dmem [`VSA_DMEM_WORDS]; // data store, no reset
    logic [ImemAw-1:0] fetchIdx;               // pc in word units

    // pc counts in steps of two
    assign fetchIdx    = ImemAw'(fetchAddr / `VSA_PC_STEP);
    assign instruction = imem[fetchIdx];

    // program load, only while the core is held in reset
    always_ff @(posedge clock) begin
        if (load.en) begin
            imem[load.addr] <= load.data;
        end
    end

    // data side
    assign readData = dmem[dataBus.addr]; // latched into LMD by the core

    always_ff @(posedge clock) begin
        if (dataBus.wr) begin
            dmem[dataBus.addr] <= dataBus.wdata; // one cycle strobe
        end
    end

endmodule

// File: source/vsaPkg.sv
// vsa package
// width types, opcode and function encodings, stage enum and bus structs

`include "vsa_config.svh"

package vsaPkg;

    typedef logic [`VSA_DATA_W-1:0]  wordT;   // data word
    typedef logic [`VSA_DATA_W-1:0]  addrT;   // pc or data address
    typedef logic [`VSA_INSTR_W-1:0] instrT;  // raw instruction
    typedef logic [1:0]              regIdxT; // R0..R3
    typedef logic [2:0]              opcodeT; // ir[11:9]
    typedef logic [2:0]              funcT;   // ir[2:0], R-format only

    // opcodes
    localparam opcodeT LW    = 3'd0;
    localparam opcodeT SW    = 3'd1;
    localparam opcodeT BEQZ  = 3'd2;
    localparam opcodeT ALUOP = 3'd3; // R-format group
    localparam opcodeT ADDI  = 3'd4;
    localparam opcodeT SUBI  = 3'd5;

    // R-format function codes
    localparam funcT ADD = 3'd0;
    localparam funcT SUB = 3'd1;
    localparam funcT AND = 3'd2;
    localparam funcT OR  = 3'd3;
    localparam funcT XOR = 3'd4;
    localparam funcT NOT = 3'd5; // ~A, B unused
    localparam funcT SRL = 3'd6; // shift right by one
    localparam funcT SRA = 3'd7; // same, sign kept

    // five stages, every instruction walks through all of them
    typedef enum logic [2:0] {IF, ID, EX, MEM, WB} stageE;

    // IR split into fields; dst and imm overlap in the raw word
    typedef struct packed {
        opcodeT opcode;
        regIdxT src1;
        regIdxT src2; // also the I-format destination
        regIdxT dst;  // R-format destination
        funcT   func;
        wordT   imm;  // ir[4:0], not sign extended
    } decodedT;

    typedef struct packed {
        addrT addr;  // ALUOutput
        wordT wdata; // B
        logic wr;    // MEM stage of SW only
    } dataBusT;

    // instruction memory load port, used while in reset
    typedef struct packed {
        logic                              en;
        logic [$clog2(`VSA_IMEM_WORDS)-1:0] addr; // word index
        instrT                             data;
    } loadPortT;

endpackage

// File: source/vsaRegFile.sv
// vsa register file
// R1..R3 plus a hardwired zero R0; two async reads, one sync write

`timescale 1ns/1ps

module vsaRegFile import vsaPkg::*; (
    input  logic   clock,
    input  logic   rstN,
    input  regIdxT rdIdxA, // src1
    input  regIdxT rdIdxB, // src2
    output wordT   rdDataA,
    output wordT   rdDataB,
    input  logic   wrEn,   // WB stage
    input  regIdxT wrIdx,
    input  wordT   wrData
);

    wordT regs [1:3]; // no storage behind R0

    // R0 reads zero whatever was written to it
    assign rdDataA = (rdIdxA == 2'd0) ? '0 : regs[rdIdxA];
    assign rdDataB = (rdIdxB == 2'd0) ? '0 : regs[rdIdxB];

    always_ff @(posedge clock) begin
        if (!rstN) begin
            for (int i = 1; i <= 3; i++) begin
                regs[i] <= '0; // all registers start at zero
            end
        end else if (wrEn && wrIdx != 2'd0) begin
            regs[wrIdx] <= wrData; // writes to R0 dropped here
        end
    end

endmodule

// File: source/vsaSystem.sv
// vsa system top
// core plus instruction and data memories
// pc and data bus brought out for observation, load port passed through

`timescale 1ns/1ps

module vsaSystem import vsaPkg::*; (
    input  logic     clock,
    input  logic     rstN,
    input  loadPortT load,    // program load from testbench
    output addrT     pc,      // fetch address
    output dataBusT  dataBus  // store address, data and strobe
);

    instrT instruction; // imem -> core
    wordT  readData;    // dmem -> core

    vsaCore core_i (
        .clock       (clock),
        .rstN        (rstN),
        .instruction (instruction),
        .readData    (readData),
        .pc          (pc),
        .dataBus     (dataBus)
    );

    // memories see the same pc and bus that leave the top
    vsaMemory mem_i (
        .clock       (clock),
        .load        (load),
        .fetchAddr   (pc),
        .instruction (instruction),
        .dataBus     (dataBus),
        .readData    (readData)
    );

endmodule

// File: source/vsa_config.svh
// vsa configuration
// widths, PC step and memory depths shared by the processor and its memories

`ifndef VSA_CONFIG_SVH
`define VSA_CONFIG_SVH

// datapath
`define VSA_DATA_W      5   // register, ALU and PC width
`define VSA_INSTR_W     12  // one instruction word

// fetch
`define VSA_PC_STEP     2   // pc advances by two per instruction

// memory sizes, in words
`define VSA_IMEM_WORDS  16  // 12-bit instruction words
`define VSA_DMEM_WORDS  32  // whole 5-bit address space

// the PC step and the instruction depth together cover the 5-bit PC:
// 16 words of 2 address units each.
// the data memory is addressed directly by ALUOutput

`endif

// File: verification/vsaClockGen.sv
// vsa clock and reset generator
// 8 ns clock; rstN held low while the testbench loads a program
// and for two more cycles after the load ends

`timescale 1ns/1ps

module vsaClockGen (
    output logic clock,
    output logic rstN,
    input  logic holdReset // high during program load
);

    int   holdCnt = 0; // cycles since holdReset dropped
    logic holdAtEdge;  // holdReset as seen by the rising edge

    initial clock = 1'b0;
    initial rstN  = 1'b0;

    always #4 clock = ~clock; // 8 ns period

    // rstN changes 1 ns after the edge like every other driven input
    always @(posedge clock) begin
        holdAtEdge = holdReset; // value before the testbench moves it
        #1;
        if (holdAtEdge) begin
            rstN    = 1'b0;
            holdCnt = 0;
        end else if (holdCnt < 1) begin
            rstN    = 1'b0; // second low cycle after the load
            holdCnt = holdCnt + 1;
        end else begin
            rstN = 1'b1;
        end
    end

endmodule

// File: verification/vsaSystem_sva.sv
// vsa core assertions
// stage range, store strobe timing and the zero register
// bound into vsaCore from the testbench

`timescale 1ns/1ps

module vsaSystem_sva import vsaPkg::*; (
    input logic   clock,
    input logic   rstN,
    input stageE  stage,
    input logic   wr,   // dataBus.wr
    input regIdxT src1, // dec.src1
    input wordT   opA,  // A register
    input regIdxT src2, // dec.src2
    input wordT   opB   // B register
);

    // FSM never leaves the five legal stages
    stageLegal: assert property (@(posedge clock) disable iff (!rstN)
        stage inside {IF, ID, EX, MEM, WB})
        else $error("core stage left the IF to WB range");

    // stores only in MEM
    wrInMem: assert property (@(posedge clock) disable iff (!rstN)
        wr |-> stage == MEM)
        else $error("write strobe outside the MEM stage");

    wrOneCycle: assert property (@(posedge clock) disable iff (!rstN)
        wr |=> !wr)
        else $error("write strobe held longer than one cycle");

    // R0 operands reach EX as zero on both sides
    zeroRegA: assert property (@(posedge clock) disable iff (!rstN)
        stage == EX && src1 == 2'd0 |-> opA == '0)
        else $error("A latched nonzero from R0");

    zeroRegB: assert property (@(posedge clock) disable iff (!rstN)
        stage == EX && src2 == 2'd0 |-> opB == '0)
        else $error("B latched nonzero from R0");

endmodule

// File: verification/vsaTb.sv
// vsa system testbench
// loads each program of the stim file, then checks the pc at every
// instruction boundary and every store on the data bus

`timescale 1ns/1ps

module vsaTb import vsaPkg::*; ();

    logic     clock;
    logic     rstN;
    logic     holdReset;
    loadPortT load;
    addrT     pc;
    dataBusT  dataBus;

    // stim contents, flattened over all sections
    logic [3:0]  progAddr[$];
    logic [11:0] progData[$];
    addrT        pcExp[$];
    addrT        stAddr[$];
    wordT        stData[$];
    int          nP[$]; // per section counts
    int          nC[$];
    int          nS[$];

    int pIdx = 0;
    int cIdx = 0;
    int sIdx = 0;
    int limitCycles = 0; // watchdog budget, set after parsing
    bit passReached = 1'b0;
    bit failReported = 1'b0;

    vsaClockGen clockGen_i (
        .clock     (clock),
        .rstN      (rstN),
        .holdReset (holdReset)
    );

    vsaSystem dut_i (
        .clock   (clock),
        .rstN    (rstN),
        .load    (load),
        .pc      (pc),
        .dataBus (dataBus)
    );

    bind vsaCore vsaSystem_sva sva_i (
        .clock (clock),
        .rstN  (rstN),
        .stage (stage),
        .wr    (dataBus.wr),
        .src1  (dec.src1),
        .opA   (a),
        .src2  (dec.src2),
        .opB   (b)
    );

    task automatic reportFailure(input string msg);
        failReported = 1'b1;
        $display("%s", msg);
        $display("Finished with errors");
        $fatal(1, "testbench stopped");
    endtask

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            failReported = 1'b1;
            $display("ERROR at %0t ns: %s is %0h, expected %0h", $time, name, actual, expected);
            $display("Finished with errors");
            $fatal(1, "check mismatch");
        end
    endtask

    // line tags P load word, C pc at boundary, S store, E end of section
    task automatic readStim();
        int               fd;
        int               code;
        int               cntP;
        int               cntC;
        int               cntS;
        logic [7:0]       tag;
        logic [31:0]      v1;
        logic [31:0]      v2;
        logic [8*128-1:0] rest;
        cntP = 0;
        cntC = 0;
        cntS = 0;
        fd = $fopen("verification/vsa_stim.txt", "r");
        if (fd == 0) begin
            reportFailure("could not open verification/vsa_stim.txt");
        end else begin
            code = $fscanf(fd, " %c", tag);
            while (code == 1) begin
                case (tag)
                    "#": code = $fgets(rest, fd); // comment line
                    "P": begin
                        code = $fscanf(fd, "%h %h", v1, v2);
                        progAddr.push_back(4'(v1));
                        progData.push_back(12'(v2));
                        cntP++;
                    end
                    "C": begin
                        code = $fscanf(fd, "%h", v1);
                        pcExp.push_back(5'(v1));
                        cntC++;
                    end
                    "S": begin
                        code = $fscanf(fd, "%h %h", v1, v2);
                        stAddr.push_back(5'(v1));
                        stData.push_back(5'(v2));
                        cntS++;
                    end
                    "E": begin
                        nP.push_back(cntP);
                        nC.push_back(cntC);
                        nS.push_back(cntS);
                        cntP = 0;
                        cntC = 0;
                        cntS = 0;
                    end
                    default: reportFailure("unknown line tag in the stim file");
                endcase
                code = $fscanf(fd, " %c", tag);
            end
            $fclose(fd);
        end
    endtask

    // load one program under reset, then follow it boundary by boundary
    task automatic runSection(input int sec);
        int cyc;
        int storesSeen;
        storesSeen = 0;
        @(posedge clock);
        #1 holdReset = 1'b1;
        for (int i = 0; i < nP[sec]; i++) begin
            @(posedge clock);
            #1;
            load.en   = 1'b1;
            load.addr = progAddr[pIdx];
            load.data = progData[pIdx];
            pIdx++;
        end
        @(posedge clock);
        #1;
        load.en   = 1'b0;
        holdReset = 1'b0;
        @(negedge clock);
        while (!rstN) @(negedge clock);
        // first negedge with rstN high is the IF cycle of instruction 0
        for (cyc = 0; cyc < 5 * nC[sec]; cyc++) begin
            if (cyc > 0) begin
                @(negedge clock);
            end
            if (cyc == 0) begin
                checkValue("pc", 32'(pc), 32'd0); // reset state
            end
            if (cyc % 5 == 0) begin
                checkValue("pc", 32'(pc), 32'(pcExp[cIdx]));
                cIdx++;
            end
            if (cyc < 3) begin
                checkValue("dataBus.wr", 32'(dataBus.wr), 32'd0);
            end
            if (dataBus.wr) begin
                if (storesSeen >= nS[sec]) begin
                    reportFailure("a store appeared that the stim file does not list");
                end else begin
                    checkValue("dataBus.wr cycle", 32'(cyc % 5), 32'd3); // MEM slot
                    checkValue("dataBus.addr", 32'(dataBus.addr), 32'(stAddr[sIdx]));
                    checkValue("dataBus.wdata", 32'(dataBus.wdata), 32'(stData[sIdx]));
                    sIdx++;
                    storesSeen++;
                end
            end
        end
        checkValue("store count", 32'(storesSeen), 32'(nS[sec]));
    endtask

    initial begin
        int total;
        total     = 0;
        holdReset = 1'b1;
        load      = '0;
        readStim();
        if (nC.size() == 0) begin
            reportFailure("the stim file holds no test section");
        end
        for (int s = 0; s < nC.size(); s++) begin
            total = total + 5 * nC[s] + 20 + nP[s]; // load time on top
        end
        limitCycles = total;
        for (int s = 0; s < nC.size(); s++) begin
            runSection(s);
        end
        passReached = 1'b1;
        $display("Finished with no errors");
        $finish;
    end

    // watchdog
    initial begin
        wait (limitCycles > 0);
        repeat (limitCycles) @(posedge clock);
        failReported = 1'b1;
        $display("watchdog expired before the programs finished");
        $display("Finished with errors");
        $fatal(1, "timeout");
    end

    final begin
        if (!passReached && !failReported) begin
            $display("Finished with errors");
        end
    end

endmodule

// File: verification/vsa_stim.txt
# P imem_word_index instruction | C expected_pc | S store_addr store_data | E end of section
# all values hex; each section is loaded under reset and ends in a BEQZ R0 self loop
# section 1: ADD SUB AND OR on R1=0d R2=16
P 0 82D
P 1 856
P 2 6D8
P 3 261
P 4 6D9
P 5 262
P 6 6DA
P 7 263
P 8 6DB
P 9 264
P a 40F
C 00
C 02
C 04
C 06
C 08
C 0a
C 0c
C 0e
C 10
C 12
C 14
C 14
C 14
S 01 03
S 02 17
S 03 04
S 04 1f
E
# section 2: XOR NOT SRL SRA, SUBI wrap, write to R0 lost
P 0 82D
P 1 856
P 2 6DC
P 3 265
P 4 6DD
P 5 266
P 6 71E
P 7 267
P 8 71F
P 9 268
P a AB4
P b 229
P c 887
P d 20A
P e 40F
C 00
C 02
C 04
C 06
C 08
C 0a
C 0c
C 0e
C 10
C 12
C 14
C 16
C 18
C 1a
C 1c
C 1c
C 1c
S 05 1b
S 06 12
S 07 0b
S 08 1b
S 09 19
S 0a 00
E
# section 3: load after store, BEQZ not taken and taken
P 0 833
P 1 22C
P 2 04C
P 3 24D
P 4 483
P 5 402
P 6 861
P 7 26E
P 8 AB3
P 9 481
P a 22E
P b 24F
P c 40F
C 00
C 02
C 04
C 06
C 08
C 0a
C 10
C 12
C 16
C 18
C 18
C 18
S 0c 13
S 0d 13
S 0f 13
E
